// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_dwc_write
RTL_TOP    := dwc_write_top
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ns
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: common/dwc_config.svh
`ifndef DWC_CONFIG_SVH
`define DWC_CONFIG_SVH

////////////////////////////////////////////////////////////
// Converter widths
////////////////////////////////////////////////////////////

// Master side, one wide beat
`define DWC_DATA_IN_W 64

// Slave side, one narrow beat
`define DWC_DATA_OUT_W 32

// Slave beat count, length minus one
`define DWC_LEN_W 8

// Byte offset inside one wide beat
`define DWC_OFFS_W 3

// AXI size code
`define DWC_SIZE_W 3

`endif

// File: common/dwc_pkg.sv
`include "dwc_config.svh"

package dwc_pkg;

   ////////////////////////////////////////////////////////////
   // Data and strobe vectors
   ////////////////////////////////////////////////////////////

   typedef logic [`DWC_DATA_IN_W-1:0]      wide_data_t;
   typedef logic [`DWC_DATA_IN_W/8-1:0]    wide_strb_t;
   typedef logic [`DWC_DATA_OUT_W-1:0]     narrow_data_t;
   typedef logic [`DWC_DATA_OUT_W/8-1:0]   narrow_strb_t;

   ////////////////////////////////////////////////////////////
   // Command fields
   ////////////////////////////////////////////////////////////

   typedef logic [`DWC_OFFS_W-1:0] byte_offs_t;
   typedef logic [`DWC_LEN_W-1:0]  beat_cnt_t;
   typedef logic [`DWC_SIZE_W-1:0] axi_size_t;

   // Four-phase command load
   typedef enum logic [1:0] {
      CMD_IDLE,
      CMD_ACK,
      CMD_BUSY
   } cmd_state_e;

endpackage

// File: compile.f
+incdir+common
common/dwc_pkg.sv
dwc/wr_cmd_regs.sv
dwc/wdata_buffer.sv
dwc/lane_sequencer.sv
src/dwc_write_top.sv
tb/tb_dwc_write.sv

// File: dwc/lane_sequencer.sv
`timescale 1ns/1ns
`include "dwc_config.svh"

module lane_sequencer
   import dwc_pkg::*;
(
   input  logic         ACLK,
   input  logic         sysReset,
   input  logic         cmd_active,
   input  byte_offs_t   start_offs,
   input  axi_size_t    beat_size,
   input  beat_cnt_t    beat_len,
   input  logic         buf_full,
   input  wide_data_t   buf_data,
   input  wide_strb_t   buf_strb,
   input  logic         s_wready,
   output logic         s_wvalid,
   output narrow_data_t s_wdata,
   output narrow_strb_t s_wstrb,
   output logic         s_wlast,
   output logic         lane_done,
   output logic         burst_done
);

   localparam int LANE_BYTES = `DWC_DATA_OUT_W / 8;
   localparam int LANE_SHIFT = $clog2(LANE_BYTES);

   logic       seq_live;
   byte_offs_t cur_offs;
   beat_cnt_t  beat_cnt;
   byte_offs_t step;
   byte_offs_t size_mask;
   byte_offs_t aligned_offs;
   byte_offs_t next_offs;
   logic       offs_wrap;
   logic       s_hs;
   logic [`DWC_OFFS_W-LANE_SHIFT-1:0] lane;

   ////////////////////////////////////////////////////////////
   // Address stepping
   ////////////////////////////////////////////////////////////

   assign step         = byte_offs_t'(1) << beat_size;
   assign size_mask    = step - byte_offs_t'(1);
   assign aligned_offs = cur_offs & ~size_mask;
   assign next_offs    = aligned_offs + step;

   // Next beat falls into the following wide beat
   assign offs_wrap = (next_offs < cur_offs);

   assign lane = cur_offs[`DWC_OFFS_W-1:LANE_SHIFT];

   ////////////////////////////////////////////////////////////
   // Slave channel
   ////////////////////////////////////////////////////////////

   assign s_wvalid = seq_live && buf_full;
   assign s_wdata  = buf_data[lane*`DWC_DATA_OUT_W +: `DWC_DATA_OUT_W];
   assign s_wstrb  = buf_strb[lane*LANE_BYTES +: LANE_BYTES];
   assign s_wlast  = s_wvalid && (beat_cnt == beat_len);

   assign s_hs       = s_wvalid && s_wready;
   assign lane_done  = s_hs && (offs_wrap || s_wlast);
   assign burst_done = s_hs && s_wlast;

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         seq_live <= 1'b0;
         cur_offs <= '0;
         beat_cnt <= '0;
      end
      else
      begin
         if (burst_done)
         begin
            seq_live <= 1'b0;
         end
         else if (cmd_active && !seq_live)
         begin
            // New command, reload from its fields
            seq_live <= 1'b1;
            cur_offs <= start_offs;
            beat_cnt <= '0;
         end
         else if (s_hs)
         begin
            cur_offs <= next_offs;
            beat_cnt <= beat_cnt + beat_cnt_t'(1);
         end
      end
   end

endmodule

// File: dwc/wdata_buffer.sv
`timescale 1ns/1ns
`include "dwc_config.svh"

module wdata_buffer
   import dwc_pkg::*;
(
   input  logic       ACLK,
   input  logic       sysReset,
   input  logic       cmd_active,
   input  logic       m_wvalid,
   input  wide_data_t m_wdata,
   input  wide_strb_t m_wstrb,
   input  logic       lane_done,
   output logic       m_wready,
   output logic       buf_full,
   output wide_data_t buf_data,
   output wide_strb_t buf_strb
);

   logic m_hs;

   ////////////////////////////////////////////////////////////
   // Master side acceptance
   ////////////////////////////////////////////////////////////

   // Empty slot, or the held beat leaves on this edge
   assign m_wready = cmd_active && (!buf_full || lane_done);
   assign m_hs     = m_wvalid && m_wready;

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         buf_full <= 1'b0;
      end
      else
      begin
         if (m_hs)
         begin
            buf_full <= 1'b1;
         end
         else if (lane_done)
         begin
            buf_full <= 1'b0;
         end
      end
   end

   // Held beat and strobes
   always_ff @(posedge ACLK)
   begin
      if (m_hs)
      begin
         buf_data <= m_wdata;
         buf_strb <= m_wstrb;
      end
   end

endmodule

// File: dwc/wr_cmd_regs.sv
`timescale 1ns/1ns
`include "dwc_config.svh"

module wr_cmd_regs
   import dwc_pkg::*;
(
   input  logic       ACLK,
   input  logic       sysReset,
   input  logic       cmd_req,
   input  byte_offs_t cmd_addr,
   input  axi_size_t  cmd_size,
   input  beat_cnt_t  cmd_len,
   input  logic       burst_done,
   output logic       cmd_ack,
   output logic       cmd_active,
   output byte_offs_t start_offs,
   output axi_size_t  beat_size,
   output beat_cnt_t  beat_len
);

   cmd_state_e state;
   logic       load_cmd;

   assign load_cmd = (state == CMD_IDLE) && cmd_req;
   assign cmd_ack  = (state == CMD_ACK);

   ////////////////////////////////////////////////////////////
   // Handshake FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         state      <= CMD_IDLE;
         cmd_active <= 1'b0;
      end
      else
      begin
         case (state)
            CMD_IDLE:
            begin
               if (cmd_req)
               begin
                  state <= CMD_ACK;
               end
            end
            CMD_ACK:
            begin
               if (!cmd_req)
               begin
                  state <= CMD_BUSY;
               end
            end
            CMD_BUSY:
            begin
               // Burst may already have ended while req was still high
               if (burst_done || !cmd_active)
               begin
                  state <= CMD_IDLE;
               end
            end
            default:
            begin
               state <= CMD_IDLE;
            end
         endcase

         if (load_cmd)
         begin
            cmd_active <= 1'b1;
         end
         else if (burst_done)
         begin
            cmd_active <= 1'b0;
         end
      end
   end

   // Command fields, held until the next load
   always_ff @(posedge ACLK)
   begin
      if (load_cmd)
      begin
         start_offs <= cmd_addr;
         beat_size  <= cmd_size;
         beat_len   <= cmd_len;
      end
   end

endmodule

// File: src/dwc_write_top.sv
`timescale 1ns/1ns
`include "dwc_config.svh"

module dwc_write_top
   import dwc_pkg::*;
(
   input  logic         ACLK,
   input  logic         sysReset,
   // Command port
   input  logic         cmd_req,
   input  byte_offs_t   cmd_addr,
   input  axi_size_t    cmd_size,
   input  beat_cnt_t    cmd_len,
   output logic         cmd_ack,
   // Master write channel
   input  logic         m_wvalid,
   input  wide_data_t   m_wdata,
   input  wide_strb_t   m_wstrb,
   output logic         m_wready,
   // Slave write channel
   input  logic         s_wready,
   output logic         s_wvalid,
   output narrow_data_t s_wdata,
   output narrow_strb_t s_wstrb,
   output logic         s_wlast
);

   logic       cmd_active;
   byte_offs_t start_offs;
   axi_size_t  beat_size;
   beat_cnt_t  beat_len;
   logic       burst_done;
   logic       lane_done;
   logic       buf_full;
   wide_data_t buf_data;
   wide_strb_t buf_strb;

   ////////////////////////////////////////////////////////////
   // Command, buffer and sequencer
   ////////////////////////////////////////////////////////////

   wr_cmd_regs u_cmd (
      .ACLK       (ACLK),
      .sysReset   (sysReset),
      .cmd_req    (cmd_req),
      .cmd_addr   (cmd_addr),
      .cmd_size   (cmd_size),
      .cmd_len    (cmd_len),
      .burst_done (burst_done),
      .cmd_ack    (cmd_ack),
      .cmd_active (cmd_active),
      .start_offs (start_offs),
      .beat_size  (beat_size),
      .beat_len   (beat_len)
   );

   wdata_buffer u_buf (
      .ACLK       (ACLK),
      .sysReset   (sysReset),
      .cmd_active (cmd_active),
      .m_wvalid   (m_wvalid),
      .m_wdata    (m_wdata),
      .m_wstrb    (m_wstrb),
      .lane_done  (lane_done),
      .m_wready   (m_wready),
      .buf_full   (buf_full),
      .buf_data   (buf_data),
      .buf_strb   (buf_strb)
   );

   lane_sequencer u_seq (
      .ACLK       (ACLK),
      .sysReset   (sysReset),
      .cmd_active (cmd_active),
      .start_offs (start_offs),
      .beat_size  (beat_size),
      .beat_len   (beat_len),
      .buf_full   (buf_full),
      .buf_data   (buf_data),
      .buf_strb   (buf_strb),
      .s_wready   (s_wready),
      .s_wvalid   (s_wvalid),
      .s_wdata    (s_wdata),
      .s_wstrb    (s_wstrb),
      .s_wlast    (s_wlast),
      .lane_done  (lane_done),
      .burst_done (burst_done)
   );

endmodule

// File: tb/dwc_cases.txt
// case  offset  size  len-1  stall  master_beats   (all hex)
// size is the AXI size code of the slave beat, len-1 counts slave beats
01 0 2 03 0 02
02 4 2 03 0 03
03 0 2 00 0 01
04 4 2 00 0 01
05 0 2 07 1 04
06 4 2 07 1 05
07 1 1 05 0 02
08 6 1 03 1 02
09 3 1 04 0 02
0a 7 1 01 1 02
0b 5 1 08 1 03
0c 3 0 07 0 02
0d 7 0 02 1 02
0e 5 0 0b 1 03
0f 0 0 03 0 01
10 6 0 00 1 01
11 2 1 0f 1 05
12 4 2 0f 1 09

// File: tb/tb_dwc_write.sv
`timescale 1ns/1ns
`include "dwc_config.svh"

module tb_dwc_write
   import dwc_pkg::*;
();

   localparam int MAX_CASES = 32;
   localparam int MAX_WIDE  = 16;
   localparam int LANE_W    = `DWC_DATA_OUT_W;

   logic         ACLK;
   logic         sysReset;
   logic         cmd_req;
   byte_offs_t   cmd_addr;
   axi_size_t    cmd_size;
   beat_cnt_t    cmd_len;
   logic         cmd_ack;
   logic         m_wvalid;
   wide_data_t   m_wdata;
   wide_strb_t   m_wstrb;
   logic         m_wready;
   logic         s_wready;
   logic         s_wvalid;
   narrow_data_t s_wdata;
   narrow_strb_t s_wstrb;
   logic         s_wlast;

   // Six fields per case line
   logic [7:0]   case_mem [0:MAX_CASES*6-1];
   wide_data_t   beat_data [0:MAX_WIDE-1];
   wide_strb_t   beat_strb [0:MAX_WIDE-1];
   logic [15:0]  lfsr_state;
   int           cycle_count = 0;
   int           cycle_limit = 0;

   dwc_write_top u_dut (
      .ACLK     (ACLK),
      .sysReset (sysReset),
      .cmd_req  (cmd_req),
      .cmd_addr (cmd_addr),
      .cmd_size (cmd_size),
      .cmd_len  (cmd_len),
      .cmd_ack  (cmd_ack),
      .m_wvalid (m_wvalid),
      .m_wdata  (m_wdata),
      .m_wstrb  (m_wstrb),
      .m_wready (m_wready),
      .s_wready (s_wready),
      .s_wvalid (s_wvalid),
      .s_wdata  (s_wdata),
      .s_wstrb  (s_wstrb),
      .s_wlast  (s_wlast)
   );

   initial
   begin
      ACLK = 1'b0;
      forever
      begin
         #20 ACLK = ~ACLK;
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic random_bit();
      logic feedback;
      feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], feedback};
      return feedback;
   endfunction

   function automatic logic [63:0] random_bits(input int count);
      logic [63:0] value;
      value = '0;
      for (int i = 0; i < count; i++)
      begin
         value = {value[62:0], random_bit()};
      end
      return value;
   endfunction

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_equal(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected)
      else
      begin
         stop_with_failure($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                                     name, expected, actual));
      end
   endtask

   // Four-phase load of one command
   task automatic send_command(input int cid, input byte_offs_t offs,
                               input axi_size_t size, input beat_cnt_t len);
      check_equal($sformatf("case %0d ack before req", cid), 64'd0, 64'(cmd_ack));
      @(posedge ACLK);
      cmd_addr <= offs;
      cmd_size <= size;
      cmd_len  <= len;
      cmd_req  <= 1'b1;
      @(negedge ACLK);
      check_equal($sformatf("case %0d ack with req", cid), 64'd0, 64'(cmd_ack));
      while (!cmd_ack)
      begin
         @(negedge ACLK);
      end
      @(posedge ACLK);
      cmd_req <= 1'b0;
      @(negedge ACLK);
      check_equal($sformatf("case %0d ack held", cid), 64'd1, 64'(cmd_ack));
      while (cmd_ack)
      begin
         @(negedge ACLK);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // One burst, master and slave models
   ////////////////////////////////////////////////////////////

   task automatic run_case(input int idx);
      int           cid;
      int           offs;
      int           size;
      int           len;
      int           exp_m;
      int           offered;
      int           m_count;
      int           s_count;
      int           wide_idx;
      int           lane;
      logic         stall;
      logic         m_take;
      logic         held;
      logic         done;
      logic         gap_bit;
      logic         rdy_bit;
      logic [37:0]  held_beat;
      string        tag;

      cid   = int'(case_mem[idx*6]);
      offs  = int'(case_mem[idx*6+1]);
      size  = int'(case_mem[idx*6+2]);
      len   = int'(case_mem[idx*6+3]);
      stall = case_mem[idx*6+4][0];
      exp_m = int'(case_mem[idx*6+5]);
      if (exp_m > MAX_WIDE)
      begin
         stop_with_failure(
            $sformatf("case %0d needs more master beats than the model holds", cid));
      end
      for (int k = 0; k < exp_m; k++)
      begin
         beat_data[k] = random_bits(64);
         beat_strb[k] = wide_strb_t'(random_bits(8));
      end
      send_command(cid, byte_offs_t'(offs), axi_size_t'(size), beat_cnt_t'(len));
      offered   = 0;
      m_count   = 0;
      s_count   = 0;
      wide_idx  = 0;
      m_take    = 1'b0;
      held      = 1'b0;
      done      = 1'b0;
      held_beat = '0;
      while (!done)
      begin
         @(posedge ACLK);
         gap_bit = stall ? random_bit() : 1'b1;
         rdy_bit = stall ? random_bit() : 1'b1;
         if (!m_wvalid || m_take)
         begin
            if (offered < exp_m && gap_bit)
            begin
               m_wvalid <= 1'b1;
               m_wdata  <= beat_data[offered];
               m_wstrb  <= beat_strb[offered];
               offered++;
            end
            else
            begin
               m_wvalid <= 1'b0;
            end
         end
         s_wready <= rdy_bit;
         // Second request stays unanswered until the burst ends
         cmd_req  <= 1'b1;

         @(negedge ACLK);
         tag = $sformatf("case %0d beat %0d", cid, s_count);
         check_equal({tag, " ack during burst"}, 64'd0, 64'(cmd_ack));
         // Stalled beat must not move
         if (held)
         begin
            check_equal({tag, " held beat"}, 64'(held_beat),
                        64'({s_wvalid, s_wlast, s_wstrb, s_wdata}));
         end
         m_take = m_wvalid && m_wready;
         if (m_take)
         begin
            m_count++;
         end
         if (s_wvalid && s_wready)
         begin
            lane = offs / 4;
            check_equal({tag, " strb and data"},
                        64'({beat_strb[wide_idx][lane*4 +: 4],
                             beat_data[wide_idx][lane*LANE_W +: LANE_W]}),
                        64'({s_wstrb, s_wdata}));
            check_equal({tag, " wlast"}, 64'(s_count == len), 64'(s_wlast));
            if (s_count == len)
            begin
               done = 1'b1;
               check_equal({tag, " master beats"}, 64'(exp_m), 64'(m_count));
               check_equal({tag, " wide beats by address"}, 64'(exp_m), 64'(wide_idx + 1));
            end
            // Up to the next size boundary, into the next wide beat past 8
            offs = ((offs >> size) + 1) << size;
            if (offs >= 8)
            begin
               offs = offs - 8;
               wide_idx++;
            end
            s_count++;
         end
         held      = s_wvalid && !s_wready;
         held_beat = {1'b1, s_wlast, s_wstrb, s_wdata};
      end

      // Withdraw the pending request on the burst end edge
      @(posedge ACLK);
      cmd_req <= 1'b0;
      @(negedge ACLK);
      check_equal($sformatf("case %0d ack after burst", cid), 64'd0, 64'(cmd_ack));
   endtask

   always @(posedge ACLK)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit)
      begin
         stop_with_failure("timeout waiting for burst end");
      end
   end

   initial
   begin
      int idx;
      int total_beats;

      lfsr_state = 16'd51428;
      sysReset   = 1'b0;
      cmd_req    = 1'b0;
      cmd_addr   = '0;
      cmd_size   = '0;
      cmd_len    = '0;
      m_wvalid   = 1'b0;
      m_wdata    = '0;
      m_wstrb    = '0;
      s_wready   = 1'b0;
      for (idx = 0; idx < MAX_CASES*6; idx++)
      begin
         case_mem[idx] = 8'hff;
      end
      $readmemh("tb/dwc_cases.txt", case_mem);
      total_beats = 0;
      for (idx = 0; idx < MAX_CASES && case_mem[idx*6] != 8'hff; idx++)
      begin
         total_beats += int'(case_mem[idx*6+3]) + 1;
      end
      if (total_beats == 0)
      begin
         stop_with_failure("no test cases found in tb/dwc_cases.txt");
      end
      cycle_limit = total_beats * 8 + 200;

      repeat (2) @(posedge ACLK);
      sysReset <= 1'b1;
      @(negedge ACLK);
      check_equal("idle outputs after reset", 64'd0,
                  64'({cmd_ack, m_wready, s_wvalid, s_wlast}));

      for (idx = 0; idx < MAX_CASES && case_mem[idx*6] != 8'hff; idx++)
      begin
         run_case(idx);
      end
      $display("All tests passed");
      $finish;
   end

endmodule
